// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := qr_slot_scan_tb
FILELIST  := qr_slot_scan.f
OBJ_DIR   := obj_dir
RUN_ARGS  := +verilator+error+limit+1000
LOG       := sim.log
FAIL_MSG  := Verification failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/qr_probe_decode.sv
`timescale 1ns/1ns

module qr_probe_decode #(
        parameter int ROW_BITS = qr_scan_pkg::img_bits
) (
        input  logic                clk,
        input  logic                srst_n,
        input  qr_scan_pkg::probe_t probe,
        output logic                sram_ren,
        output qr_scan_pkg::addr_t  sram_raddr,
        output qr_scan_pkg::probe_t sample
);
        import qr_scan_pkg::*;

        // Offsets of the current step inside the window.
        logic [2:0] dr;
        logic [2:0] dc;

        // Absolute pixel position.
        coord_t row;
        coord_t col;

        // Tag in step with sram_raddr.
        probe_t tag_q;

        ////////////////////////////////////////
        // Pattern lookup.
        ////////////////////////////////////////

        always_comb begin
                dr = '0;
                dc = '0;
                // Steps past the table never carry valid.
                if (probe.step < step_t'(PATTERN_LEN)) begin
                        dr = PAT_DR[probe.step];
                        dc = PAT_DC[probe.step];
                end
                row = SLOT_ROW[probe.slot] + coord_t'(dr);
                col = SLOT_COL[probe.slot] + coord_t'(dc);
        end

        ////////////////////////////////////////
        // Address register.
        ////////////////////////////////////////

        // Row major, one bit per pixel.
        always_ff @(posedge clk) begin
                sram_raddr <= (addr_t'(row) << ROW_BITS) + addr_t'(col);
        end

        // First tag stage, valid doubles as the read enable.
        always_ff @(posedge clk) begin
                if (!srst_n) begin
                        tag_q <= '0;
                end else begin
                        tag_q <= probe;
                end
        end

        assign sram_ren = tag_q.valid;

        ////////////////////////////////////////
        // Tag return.
        ////////////////////////////////////////

        // SRAM answers one cycle after ren.
        // So the tag lands together with sram_rdata.
        always_ff @(posedge clk) begin
                if (!srst_n) begin
                        sample <= '0;
                end else begin
                        sample <= tag_q;
                end
        end

endmodule

// File: design/qr_scan_ctrl.sv
`timescale 1ns/1ns

module qr_scan_ctrl (
        input  logic                   clk,
        input  logic                   srst_n,
        input  logic                   req,
        output logic                   ack,
        output qr_scan_pkg::probe_t    probe,
        input  qr_scan_pkg::probe_t    sample,
        input  logic                   sram_rdata,
        output qr_scan_pkg::slot_evt_t evt,
        output logic                   clear
);
        import qr_scan_pkg::*;

        localparam step_t LAST_STEP = step_t'(PATTERN_LEN - 1);
        localparam slot_t LAST_SLOT = slot_t'(NUM_SLOTS - 1);

        scan_state_e state_q;

        // Slot being scanned.
        slot_t slot_q;

        // Next step to issue.
        step_t step_q;

        // Sample belongs to the current slot.
        logic accept;
        logic hit;
        logic resolve;

        ////////////////////////////////////////
        // Sample check.
        ////////////////////////////////////////

        // Samples of an already resolved slot are stale.
        always_comb begin
                accept = sample.valid && (sample.slot == slot_q) &&
                         ((state_q == scan_probe) || (state_q == scan_drain));
                hit = accept && sram_rdata;
                // Found on a set pixel, empty after the last clean step.
                resolve = hit || (accept && (sample.step == LAST_STEP));
        end

        ////////////////////////////////////////
        // Outputs.
        ////////////////////////////////////////

        // No issue in the resolving cycle.
        // Keeps the bus quiet once the last slot ends.
        assign probe.valid = (state_q == scan_probe) && !resolve;
        assign probe.slot  = slot_q;
        assign probe.step  = step_q;

        assign evt.valid = resolve;
        assign evt.slot  = slot_q;
        assign evt.hit   = hit;

        // Start of a new scan.
        assign clear = (state_q == scan_idle) && req;

        // Results held while ack is high.
        assign ack = (state_q == scan_done);

        ////////////////////////////////////////
        // Sequencer.
        ////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (!srst_n) begin
                        state_q <= scan_idle;
                        slot_q  <= '0;
                        step_q  <= '0;
                end else begin
                        case (state_q)
                        scan_idle: begin
                                if (req) begin
                                        state_q <= scan_probe;
                                        slot_q  <= '0;
                                        step_q  <= '0;
                                end
                        end
                        scan_probe, scan_drain: begin
                                if (resolve) begin
                                        // Early exit, drop the rest of this slot.
                                        step_q <= '0;
                                        slot_q <= slot_q + slot_t'(1);
                                        if (slot_q == LAST_SLOT) begin
                                                state_q <= scan_done;
                                        end else begin
                                                state_q <= scan_probe;
                                        end
                                end else if (state_q == scan_probe) begin
                                        // Wait for step 24 to come back.
                                        if (step_q == LAST_STEP) begin
                                                state_q <= scan_drain;
                                        end else begin
                                                step_q <= step_q + step_t'(1);
                                        end
                                end
                        end
                        scan_done: begin
                                // Four-phase, ack drops after req.
                                if (!req) begin
                                        state_q <= scan_idle;
                                end
                        end
                        default: begin
                                state_q <= scan_idle;
                        end
                        endcase
                end
        end

endmodule

// File: design/qr_scan_pkg.sv
package qr_scan_pkg;

        ////////////////////////////////////////
        // Image geometry.
        ////////////////////////////////////////

        // Log2 of the image side, 64 x 64 pixels.
        parameter int img_bits = 6;

        // Number of candidate windows.
        parameter int NUM_SLOTS = 4;

        // Probes per 5 x 5 window.
        parameter int PATTERN_LEN = 25;

        // One-bit pixel address, row * 64 + col.
        typedef logic [2*img_bits-1:0] addr_t;

        // Row or column index.
        typedef logic [img_bits-1:0] coord_t;

        typedef logic [1:0] slot_t;
        typedef logic [4:0] step_t;

        // Zero to four found windows.
        typedef logic [2:0] total_t;

        ////////////////////////////////////////
        // Window origins and probe pattern.
        ////////////////////////////////////////

        // Top-left corners, clockwise from top-left slot.
        localparam coord_t SLOT_ROW [NUM_SLOTS] = '{6'd19, 6'd19, 6'd40, 6'd40};
        localparam coord_t SLOT_COL [NUM_SLOTS] = '{6'd19, 6'd40, 6'd40, 6'd19};

        // Outer ring clockwise from the corner, then the inner 3 x 3 row by row.
        localparam logic [2:0] PAT_DR [PATTERN_LEN] = '{
                3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4,
                3'd4, 3'd4, 3'd4, 3'd4, 3'd3, 3'd2, 3'd1,
                3'd1, 3'd1, 3'd1, 3'd2, 3'd2, 3'd2, 3'd3, 3'd3, 3'd3};
        localparam logic [2:0] PAT_DC [PATTERN_LEN] = '{
                3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd4, 3'd4, 3'd4, 3'd4,
                3'd3, 3'd2, 3'd1, 3'd0, 3'd0, 3'd0, 3'd0,
                3'd1, 3'd2, 3'd3, 3'd1, 3'd2, 3'd3, 3'd1, 3'd2, 3'd3};

        ////////////////////////////////////////
        // Control types.
        ////////////////////////////////////////

        typedef enum logic [1:0] {
                scan_idle,
                scan_probe,
                scan_drain,
                scan_done
        } scan_state_e;

        // Probe tag, issued by ctrl and returned with the read data.
        typedef struct packed {
                logic  valid;
                slot_t slot;
                step_t step;
        } probe_t;

        // One slot resolution.
        typedef struct packed {
                logic  valid;
                slot_t slot;
                logic  hit;
        } slot_evt_t;

endpackage

// File: design/qr_slot_scan.sv
`timescale 1ns/1ns

module qr_slot_scan #(
        parameter int ROW_BITS = qr_scan_pkg::img_bits
) (
        input  logic                clk,
        input  logic                srst_n,
        input  logic                req,
        output logic                ack,
        output logic                sram_ren,
        output qr_scan_pkg::addr_t  sram_raddr,
        input  logic                sram_rdata,
        output qr_scan_pkg::total_t qr_total,
        output logic [3:0]          qr_found
);
        import qr_scan_pkg::*;

        // Ctrl to decode.
        probe_t probe;

        // Decode back to ctrl, aligned with sram_rdata.
        probe_t sample;

        // Ctrl to tally.
        slot_evt_t evt;
        logic clear;

        ////////////////////////////////////////
        // Execute.
        ////////////////////////////////////////

        qr_scan_ctrl u_ctrl (
                .clk        (clk),
                .srst_n     (srst_n),
                .req        (req),
                .ack        (ack),
                .probe      (probe),
                .sample     (sample),
                .sram_rdata (sram_rdata),
                .evt        (evt),
                .clear      (clear)
        );

        ////////////////////////////////////////
        // Decode.
        ////////////////////////////////////////

        qr_probe_decode #(
                .ROW_BITS (ROW_BITS)
        ) u_decode (
                .clk        (clk),
                .srst_n     (srst_n),
                .probe      (probe),
                .sram_ren   (sram_ren),
                .sram_raddr (sram_raddr),
                .sample     (sample)
        );

        ////////////////////////////////////////
        // Result.
        ////////////////////////////////////////

        qr_slot_tally u_tally (
                .clk      (clk),
                .srst_n   (srst_n),
                .clear    (clear),
                .evt      (evt),
                .qr_total (qr_total),
                .qr_found (qr_found)
        );

endmodule

// File: design/qr_slot_tally.sv
`timescale 1ns/1ns

module qr_slot_tally (
        input  logic                   clk,
        input  logic                   srst_n,
        input  logic                   clear,
        input  qr_scan_pkg::slot_evt_t evt,
        output qr_scan_pkg::total_t    qr_total,
        output logic [3:0]             qr_found
);
        import qr_scan_pkg::*;

        // Counted event.
        logic found_evt;

        assign found_evt = evt.valid && evt.hit;

        ////////////////////////////////////////
        // Count and mask.
        ////////////////////////////////////////

        // Cleared on reset and at each new scan.
        always_ff @(posedge clk) begin
                if (!srst_n || clear) begin
                        qr_total <= '0;
                        qr_found <= '0;
                end else if (found_evt) begin
                        qr_total <= qr_total + total_t'(1);
                        // One bit per slot, ordered as the origins.
                        qr_found[evt.slot] <= 1'b1;
                end
        end

endmodule

// File: qr_slot_scan.f
design/qr_scan_pkg.sv
design/qr_probe_decode.sv
design/qr_scan_ctrl.sv
design/qr_slot_tally.sv
design/qr_slot_scan.sv
test/qr_slot_scan_checker.sv
test/qr_slot_scan_tb.sv

// File: test/qr_slot_scan_checker.sv
`timescale 1ns/1ns

module qr_slot_scan_checker (
        input logic               clk,
        input logic               srst_n,
        input logic               req,
        input logic               ack,
        input logic               sram_ren,
        input qr_scan_pkg::addr_t sram_raddr
);
        import qr_scan_pkg::*;

        // Failed assertion tally.
        int fail_count = 0;

        // Pixel lies in one of the four 5 x 5 windows.
        function automatic logic in_window(addr_t a);
                coord_t row;
                coord_t col;
                row = a[2*img_bits-1:img_bits];
                col = a[img_bits-1:0];
                return (row inside {[6'd19:6'd23], [6'd40:6'd44]}) &&
                       (col inside {[6'd19:6'd23], [6'd40:6'd44]});
        endfunction

        ////////////////////////////////////////
        // Handshake.
        ////////////////////////////////////////

        // Ack gone once req has been low two cycles.
        ack_release: assert property (@(posedge clk) disable iff (!srst_n)
                (!req && !$past(req)) |-> !ack)
                else begin
                        fail_count++;
                        $error("ack still high two cycles after req fell");
                end

        // No reads while results are presented.
        quiet_when_done: assert property (@(posedge clk) disable iff (!srst_n)
                ack |-> !sram_ren)
                else begin
                        fail_count++;
                        $error("sram_ren high while ack is high");
                end

        ////////////////////////////////////////
        // SRAM reads.
        ////////////////////////////////////////

        addr_in_window: assert property (@(posedge clk) disable iff (!srst_n)
                sram_ren |-> in_window(sram_raddr))
                else begin
                        fail_count++;
                        $error("read address 0x%0h outside all windows", sram_raddr);
                end

endmodule

bind qr_slot_scan qr_slot_scan_checker chk0 (
        .clk        (clk),
        .srst_n     (srst_n),
        .req        (req),
        .ack        (ack),
        .sram_ren   (sram_ren),
        .sram_raddr (sram_raddr)
);

// File: test/qr_slot_scan_tb.sv
`timescale 1ns/1ns

module qr_slot_scan_tb;
        import qr_scan_pkg::*;

        localparam int ACK_TIMEOUT = 400;

        logic       clk;
        logic       srst_n;
        logic       req;
        logic       ack;
        logic       sram_ren;
        addr_t      sram_raddr;
        logic       sram_rdata = 1'b0;
        total_t     qr_total;
        logic [3:0] qr_found;

        // Image, one bit per pixel, and every address the DUT read.
        logic   img [0:4095];
        logic   next_rdata = 1'b0;
        addr_t  read_log [$];
        int     scan_base;
        int     mismatches;
        int     other_errors;
        integer seed;

        qr_slot_scan dut0 (.*);

        // 8 ns clock.
        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        ////////////////////////////////////////
        // SRAM model.
        ////////////////////////////////////////

        // Address taken mid cycle, data shows up in the following cycle.
        always @(negedge clk) begin
                sram_rdata <= next_rdata;
                if (sram_ren) begin
                        next_rdata <= img[sram_raddr];
                        read_log.push_back(sram_raddr);
                end
        end

        ////////////////////////////////////////
        // Reference model.
        ////////////////////////////////////////

        function automatic int origin_row(int s);
                return (s < 2) ? 19 : 40;
        endfunction

        function automatic int origin_col(int s);
                return (s == 1 || s == 2) ? 40 : 19;
        endfunction

        // Top row, right column, bottom row backwards, left column up, then inner 3 x 3.
        function automatic int probe_dr(int k);
                if (k <= 4) return 0;
                if (k <= 8) return k - 4;
                if (k <= 12) return 4;
                if (k <= 15) return 16 - k;
                return 1 + (k - 16) / 3;
        endfunction

        function automatic int probe_dc(int k);
                if (k <= 4) return k;
                if (k <= 8) return 4;
                if (k <= 12) return 12 - k;
                if (k <= 15) return 0;
                return 1 + (k - 16) % 3;
        endfunction

        function automatic addr_t expected_addr(int s, int k);
                return addr_t'((origin_row(s) + probe_dr(k)) * 64 + origin_col(s) + probe_dc(k));
        endfunction

        // A slot counts when any of its 25 pixels is set.
        function automatic logic [3:0] reference_mask();
                logic [3:0] m;
                int         a;
                m = 4'b0000;
                for (int s = 0; s < 4; s++) begin
                        for (int r = 0; r < 5; r++) begin
                                for (int c = 0; c < 5; c++) begin
                                        a = (origin_row(s) + r) * 64 + origin_col(s) + c;
                                        if (img[addr_t'(a)])
                                                m = m | (4'b0001 << s);
                                end
                        end
                end
                return m;
        endfunction

        function automatic total_t count_bits(logic [3:0] m);
                total_t t;
                t = '0;
                for (int s = 0; s < 4; s++) begin
                        if (((m >> s) & 4'b0001) != 4'b0000) t = t + 3'd1;
                end
                return t;
        endfunction

        ////////////////////////////////////////
        // Helpers.
        ////////////////////////////////////////

        task automatic clear_image();
                foreach (img[i]) img[i] = 1'b0;
        endtask

        task automatic set_pixel(int r, int c);
                img[addr_t'(r * 64 + c)] = 1'b1;
        endtask

        task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
                if (got !== exp) begin
                        $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
                        mismatches++;
                end
        endtask

        task automatic finish_run();
                int assert_fails;
                assert_fails = dut0.chk0.fail_count;
                $display("Errors: %0d mismatches, %0d other, %0d assertions",
                         mismatches, other_errors, assert_fails);
                if (mismatches + other_errors + assert_fails == 0) begin
                        $display("Verification passed");
                end else begin
                        $display("Verification failed");
                end
                $finish;
        endtask

        // Raise req and wait for ack, then check the results.
        task automatic scan(string tname, total_t exp_total, logic [3:0] exp_mask);
                int cycles;
                scan_base = read_log.size();
                req = 1'b1;
                cycles = 0;
                while (!ack && cycles < ACK_TIMEOUT) begin
                        @(negedge clk);
                        cycles++;
                end
                if (!ack) begin
                        $display("Timeout in %s: ack did not rise after req", tname);
                        other_errors++;
                end else begin
                        check_value({tname, " qr_total"}, 32'(qr_total), 32'(exp_total));
                        check_value({tname, " qr_found"}, 32'(qr_found), 32'(exp_mask));
                end
        endtask

        // Ack must drop one cycle after req.
        task automatic release_req();
                req = 1'b0;
                @(negedge clk);
                check_value("ack after req low", 32'(ack), 32'd0);
        endtask

        ////////////////////////////////////////
        // Directed tests.
        ////////////////////////////////////////

        task automatic empty_image();
                clear_image();
                scan("empty", 3'd0, 4'h0);
                release_req();
                check_value("empty read count", 32'(read_log.size() - scan_base), 32'd100);
                if (read_log.size() - scan_base == 100) begin
                        for (int s = 0; s < 4; s++) begin
                                for (int k = 0; k < 25; k++) begin
                                        check_value("empty sram_raddr",
                                                    32'(read_log[scan_base + s * 25 + k]),
                                                    32'(expected_addr(s, k)));
                                end
                        end
                end
        endtask

        task automatic full_windows();
                clear_image();
                for (int s = 0; s < 4; s++) begin
                        for (int k = 0; k < 25; k++)
                                set_pixel(origin_row(s) + probe_dr(k),
                                          origin_col(s) + probe_dc(k));
                end
                scan("full", 3'd4, 4'hf);
                release_req();
        endtask

        task automatic last_step_hit();
                clear_image();
                set_pixel(43, 43);
                scan("last step", 3'd1, 4'h4);
                release_req();
        endtask

        // Neighbours just past the window edges too.
        task automatic outside_pixels();
                clear_image();
                for (int c = 0; c < 64; c++) set_pixel(0, c);
                set_pixel(30, 30);
                set_pixel(18, 19);
                set_pixel(24, 23);
                set_pixel(45, 40);
                scan("outside", 3'd0, 4'h0);
                release_req();
        endtask

        task automatic random_images();
                logic [3:0] m;
                for (int n = 0; n < 8; n++) begin
                        // About one pixel in 64.
                        for (int i = 0; i < 4096; i++)
                                img[addr_t'(i)] = (($random(seed) & 32'h3f) == 32'd0);
                        m = reference_mask();
                        scan("random", count_bits(m), m);
                        release_req();
                end
        endtask

        task automatic held_handshake();
                clear_image();
                set_pixel(21, 42);
                scan("hold first", 3'd1, 4'h2);
                repeat (20) begin
                        @(negedge clk);
                        check_value("held ack", 32'(ack), 32'd1);
                        check_value("held qr_found", 32'(qr_found), 32'h2);
                end
                release_req();
                // Slot 1 bit must not survive into the next scan.
                clear_image();
                set_pixel(44, 19);
                scan("hold second", 3'd1, 4'h8);
                release_req();
        endtask

        initial begin
                mismatches = 0;
                other_errors = 0;
                seed = 32'h08c732c2;
                srst_n = 1'b0;
                req = 1'b0;
                clear_image();
                repeat (16) @(negedge clk);
                srst_n = 1'b1;
                @(negedge clk);
                check_value("reset ack", 32'(ack), 32'd0);
                check_value("reset sram_ren", 32'(sram_ren), 32'd0);
                check_value("reset qr_total", 32'(qr_total), 32'd0);
                check_value("reset qr_found", 32'(qr_found), 32'd0);
                empty_image();
                full_windows();
                last_step_hit();
                outside_pixels();
                random_images();
                held_handshake();
                finish_run();
        end

endmodule
